//--- project.f
+incdir+source
source/nn_pkg.sv
source/float_mult.sv
source/float_adder.sv
source/neuron.sv
source/neuron_layer.sv
tb/neuron_layer_assertions.sv
tb/neuron_layer_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the neuron layer testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module neuron_layer_tb \
	-f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/Vneuron_layer_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0

//--- source/float_adder.sv
`timescale 1ns/10ps
`include "nn_macros.svh"

module float_adder import nn_pkg::*;
(
	input  float32_t a,
	input  float32_t b,
	output float32_t sum
);
	localparam int EW = `NN_EXP_BITS;
	localparam int MW = `NN_MAN_BITS;
	localparam int SW = MW + 1;
	localparam int LZW = $clog2(SW);
	localparam int EXP_MAX = (1 << EW) - 1;

	// position of the leading one counted from the msb.
	function automatic logic [LZW-1:0] leadingZeros(input logic [SW-1:0] value);
		logic [LZW-1:0] count;
		count = '0;
		for (int i = 0; i < SW; i++)
		begin
			if (value[i])
				count = LZW'(SW - 1 - i);
		end
		return count;
	endfunction

	logic [EW+MW-1:0] aMag;
	logic [EW+MW-1:0] bMag;
	logic swap;
	float32_t bigOp;
	float32_t smallOp;
	logic [SW-1:0] bigSig;
	logic [SW-1:0] smallSig;
	logic [SW-1:0] alignedSig;
	logic [EW-1:0] expDiff;
	logic [SW:0] rawSum;
	logic [LZW-1:0] shift;
	logic [SW-1:0] normSig;
	logic signed [EW+1:0] expRes;

	always_comb
	begin
		// flushed subnormals order as zero.
		aMag = (a.exponent == '0) ? '0 : {a.exponent, a.mantissa};
		bMag = (b.exponent == '0) ? '0 : {b.exponent, b.mantissa};
		swap = (bMag > aMag);
		bigOp = swap ? b : a;
		smallOp = swap ? a : b;

		bigSig = (bigOp.exponent == '0) ? '0 : {1'b1, bigOp.mantissa};
		smallSig = (smallOp.exponent == '0) ? '0 : {1'b1, smallOp.mantissa};

		// bits shifted out are simply lost, no guard or sticky bits.
		expDiff = bigOp.exponent - smallOp.exponent;
		alignedSig = smallSig >> expDiff;

		// bigSig is never below alignedSig, so the difference stays positive.
		if (bigOp.sign == smallOp.sign)
			rawSum = {1'b0, bigSig} + {1'b0, alignedSig};
		else
			rawSum = {1'b0, bigSig} - {1'b0, alignedSig};

		shift = leadingZeros(rawSum[SW-1:0]);
		if (rawSum[SW])
		begin
			normSig = rawSum[SW:1];
			expRes = {2'b00, bigOp.exponent} + 1;
		end
		else
		begin
			normSig = rawSum[SW-1:0] << shift;
			expRes = {2'b00, bigOp.exponent} - {{(EW+2-LZW){1'b0}}, shift};
		end

		sum.sign = bigOp.sign;
		sum.exponent = expRes[EW-1:0];
		sum.mantissa = normSig[MW-1:0];
		if (rawSum == '0)
		begin
			// exact cancellation, always positive zero.
			sum = '0;
		end
		else if (expRes <= 0)
		begin
			sum.exponent = '0;
			sum.mantissa = '0;
		end
		else if (expRes >= EXP_MAX)
		begin
			sum.exponent = '1;
			sum.mantissa = '0;
		end
	end

endmodule

//--- source/float_mult.sv
`timescale 1ns/10ps
`include "nn_macros.svh"

module float_mult import nn_pkg::*;
(
	input  float32_t x,
	input  float32_t y,
	output float32_t z
);
	localparam int EW = `NN_EXP_BITS;
	localparam int MW = `NN_MAN_BITS;
	localparam int SW = MW + 1;
	localparam int EXP_MAX = (1 << EW) - 1;
	localparam logic [EW+1:0] EXP_BIAS = `NN_EXP_BIAS;

	logic sign;
	logic anyZero;
	logic [2*SW-1:0] product;
	logic signed [EW+1:0] expSum;
	logic signed [EW+1:0] expNorm;
	logic [MW-1:0] manNorm;

	always_comb
	begin
		sign = x.sign ^ y.sign;
		// a zero exponent field is zero or a flushed subnormal.
		anyZero = (x.exponent == '0) || (y.exponent == '0);

		product = {1'b1, x.mantissa} * {1'b1, y.mantissa};
		// two extra bits keep the biased sum signed and wide enough.
		expSum = {2'b00, x.exponent} + {2'b00, y.exponent} - EXP_BIAS;

		// the significand product lies in [1, 4), so one shift at most.
		if (product[2*SW-1])
		begin
			manNorm = product[2*SW-2 -: MW];
			expNorm = expSum + 1;
		end
		else
		begin
			manNorm = product[2*SW-3 -: MW];
			expNorm = expSum;
		end

		z.sign = sign;
		z.exponent = expNorm[EW-1:0];
		z.mantissa = manNorm;
		if (anyZero || expNorm <= 0)
		begin
			z.exponent = '0;
			z.mantissa = '0;
		end
		else if (expNorm >= EXP_MAX)
		begin
			// overflow saturates to a signed infinity.
			z.exponent = '1;
			z.mantissa = '0;
		end
	end

endmodule

//--- source/layer_weights.svh
`ifndef LAYER_WEIGHTS_SVH
`define LAYER_WEIGHTS_SVH

// node 0.
`define NODE0_W0 32'h3EDFA970
`define NODE0_W1 32'h3DABAF16
`define NODE0_W2 32'h3EDD70FD
`define NODE0_W3 32'hBDF596DF
`define NODE0_W4 32'h3E9EA608
`define NODE0_W5 32'h3E8F2361
`define NODE0_W6 32'hBF01731B
`define NODE0_W7 32'h3EC2CEA5
`define NODE0_W8 32'h3EA99917
`define NODE0_W9 32'hBDA7F4AE
`define NODE0_W10 32'hBDF1594E
`define NODE0_W11 32'h3E954DCE
`define NODE0_W12 32'hBE4F5B13
`define NODE0_W13 32'hBF4D47D1
`define NODE0_W14 32'hBE5E7F56
`define NODE0_B 32'h3D020482

// node 1.
`define NODE1_W0 32'hBE8A3D71
`define NODE1_W1 32'h3E23D70A
`define NODE1_W2 32'h3F1C28F6
`define NODE1_W3 32'hBDCCCCCD
`define NODE1_W4 32'h3E6B851F
`define NODE1_W5 32'hBF0A3D71
`define NODE1_W6 32'h3D75C28F
`define NODE1_W7 32'h3EB851EC
`define NODE1_W8 32'hBE4CCCCD
`define NODE1_W9 32'h3F333333
`define NODE1_W10 32'hBEE147AE
`define NODE1_W11 32'h3DF5C28F
`define NODE1_W12 32'h3E99999A
`define NODE1_W13 32'hBF19999A
`define NODE1_W14 32'h3E0F5C29
`define NODE1_B 32'hBD4CCCCD

// node 2.
`define NODE2_W0 32'h3F0CCCCD
`define NODE2_W1 32'hBEA3D70A
`define NODE2_W2 32'h3DA3D70A
`define NODE2_W3 32'h3EE66666
`define NODE2_W4 32'hBE75C28F
`define NODE2_W5 32'h3E3851EC
`define NODE2_W6 32'hBF266666
`define NODE2_W7 32'h3D8F5C29
`define NODE2_W8 32'h3ECCCCCD
`define NODE2_W9 32'hBE0A3D71
`define NODE2_W10 32'h3F051EB8
`define NODE2_W11 32'hBDB851EC
`define NODE2_W12 32'h3E570A3D
`define NODE2_W13 32'hBEC28F5C
`define NODE2_W14 32'h3F47AE14
`define NODE2_B 32'h3E000000

`endif

//--- source/neuron.sv
`timescale 1ns/10ps
`include "nn_macros.svh"

module neuron import nn_pkg::*;
#(
	parameter float32_t [`NN_NUM_INPUTS-1:0] WEIGHTS = '0,
	parameter float32_t BIAS = '0
)
(
	input  float32_t [`NN_NUM_INPUTS-1:0] x,
	input  activation_t activation,
	output float32_t y
);
	// the bias takes the last leaf, which fills the tree to a power of two.
	localparam int LEAVES = `NN_NUM_INPUTS + 1;
	localparam int LEVELS = $clog2(LEAVES);
	localparam int TREE_NODES = 2 * LEAVES - 1;

	// leaves first, then each level of partial sums in order.
	float32_t treeNode [TREE_NODES];
	float32_t total;

	genvar i;
	genvar level;
	genvar j;

	for (i = 0; i < `NN_NUM_INPUTS; i++)
	begin : genMult
		float_mult uMult
		(
			.x(x[i]),
			.y(WEIGHTS[i]),
			.z(treeNode[i])
		);
	end

	assign treeNode[LEAVES-1] = BIAS;

	// pairs neighbours: 0+1, 2+3 and so on, with product 14 meeting the bias.
	for (level = 0; level < LEVELS; level++)
	begin : genLevel
		localparam int IN_BASE = 2 * LEAVES - ((2 * LEAVES) >> level);
		localparam int OUT_BASE = 2 * LEAVES - (LEAVES >> level);

		for (j = 0; j < (LEAVES >> (level + 1)); j++)
		begin : genAdd
			float_adder uAdd
			(
				.a(treeNode[IN_BASE + 2 * j]),
				.b(treeNode[IN_BASE + 2 * j + 1]),
				.sum(treeNode[OUT_BASE + j])
			);
		end
	end

	assign total = treeNode[TREE_NODES-1];

	// relu clamps anything with the sign bit set, negative zero included.
	assign y = (activation == ACT_RELU && total.sign) ? '0 : total;

endmodule

//--- source/neuron_layer.sv
`timescale 1ns/10ps
`include "nn_macros.svh"
`include "layer_weights.svh"

module neuron_layer import nn_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic inValid,
	input  layerIn_t sampleIn,
	output logic outValid,
	output layerOut_t result
);
	localparam float32_t [`NN_NUM_NODES-1:0][`NN_NUM_INPUTS-1:0] NODE_WEIGHTS = {
		{`NODE2_W14, `NODE2_W13, `NODE2_W12, `NODE2_W11, `NODE2_W10,
			`NODE2_W9, `NODE2_W8, `NODE2_W7, `NODE2_W6, `NODE2_W5,
			`NODE2_W4, `NODE2_W3, `NODE2_W2, `NODE2_W1, `NODE2_W0},
		{`NODE1_W14, `NODE1_W13, `NODE1_W12, `NODE1_W11, `NODE1_W10,
			`NODE1_W9, `NODE1_W8, `NODE1_W7, `NODE1_W6, `NODE1_W5,
			`NODE1_W4, `NODE1_W3, `NODE1_W2, `NODE1_W1, `NODE1_W0},
		{`NODE0_W14, `NODE0_W13, `NODE0_W12, `NODE0_W11, `NODE0_W10,
			`NODE0_W9, `NODE0_W8, `NODE0_W7, `NODE0_W6, `NODE0_W5,
			`NODE0_W4, `NODE0_W3, `NODE0_W2, `NODE0_W1, `NODE0_W0}
	};

	localparam float32_t [`NN_NUM_NODES-1:0] NODE_BIAS = {
		`NODE2_B,
		`NODE1_B,
		`NODE0_B
	};

	layerIn_t sampleReg;
	logic sampleValid;
	float32_t nodeOut [`NN_NUM_NODES];

	// input stage.
	always_ff @(posedge clk)
	begin
		if (rst)
			sampleValid <= 1'b0;
		else
			sampleValid <= inValid;
	end

	always_ff @(posedge clk)
	begin
		if (inValid)
			sampleReg <= sampleIn;
	end

	genvar n;

	// every node sees the same vector and mode.
	for (n = 0; n < `NN_NUM_NODES; n++)
	begin : genNode
		neuron
		#(
			.WEIGHTS(NODE_WEIGHTS[n]),
			.BIAS(NODE_BIAS[n])
		)
		uNeuron
		(
			.x(sampleReg.values),
			.activation(sampleReg.activation),
			.y(nodeOut[n])
		);
	end

	// the output register holds result until the next valid vector.
	always_ff @(posedge clk)
	begin
		if (rst)
			outValid <= 1'b0;
		else
			outValid <= sampleValid;
	end

	always_ff @(posedge clk)
	begin
		if (sampleValid && !rst)
		begin
			for (int k = 0; k < `NN_NUM_NODES; k++)
				result.nodes[k] <= nodeOut[k];
		end
	end

endmodule

//--- source/nn_macros.svh
`ifndef NN_MACROS_SVH
`define NN_MACROS_SVH

// layer shape.
`define NN_NUM_INPUTS 15
`define NN_NUM_NODES 3

// single precision field widths.
`define NN_EXP_BITS 8
`define NN_MAN_BITS 23

// exponent bias of the single precision format.
`define NN_EXP_BIAS 127

`endif

//--- source/nn_pkg.sv
`include "nn_macros.svh"

package nn_pkg;

	// ieee-754 single precision, sign in the top bit.
	typedef struct packed {
		logic sign;
		logic [`NN_EXP_BITS-1:0] exponent;
		logic [`NN_MAN_BITS-1:0] mantissa;
	} float32_t;

	// relu for hidden layers, linear for an output layer.
	typedef enum logic {
		ACT_RELU = 1'b0,
		ACT_LINEAR = 1'b1
	} activation_t;

	// one input vector together with the mode it is evaluated in.
	typedef struct packed {
		activation_t activation;
		float32_t [`NN_NUM_INPUTS-1:0] values;
	} layerIn_t;

	// one result per node.
	typedef struct packed {
		float32_t [`NN_NUM_NODES-1:0] nodes;
	} layerOut_t;

endpackage

//--- tb/neuron_layer_assertions.sv
`timescale 1ns/10ps

module neuron_layer_assertions
(
	input logic clk,
	input logic rst,
	input logic inValid,
	input logic outValid
);

	// output stage is cleared by the same reset.
	resetClears: assert property (@(posedge clk) $past(rst) |-> !outValid)
	else
		$error("outValid high in the cycle after reset");

	// two register stages between strobe in and strobe out.
	strobeArrives: assert property (@(posedge clk) disable iff (rst)
		$past(inValid, 2) && !$past(rst) && !$past(rst, 2) |-> outValid)
	else
		$error("inValid not followed by outValid two cycles later");

	strobeHasSource: assert property (@(posedge clk) disable iff (rst)
		outValid |-> $past(inValid, 2))
	else
		$error("outValid without an inValid two cycles earlier");

endmodule

bind neuron_layer neuron_layer_assertions uAssertions
(
	.clk(clk),
	.rst(rst),
	.inValid(inValid),
	.outValid(outValid)
);

//--- tb/neuron_layer_tb.sv
`timescale 1ns/10ps
`include "nn_macros.svh"
`include "layer_weights.svh"

module neuron_layer_tb import nn_pkg::*; ();

	localparam logic [31:0] WEIGHTS [`NN_NUM_NODES][`NN_NUM_INPUTS] = '{
		'{`NODE0_W0, `NODE0_W1, `NODE0_W2, `NODE0_W3, `NODE0_W4, `NODE0_W5, `NODE0_W6,
			`NODE0_W7, `NODE0_W8, `NODE0_W9, `NODE0_W10, `NODE0_W11, `NODE0_W12,
			`NODE0_W13, `NODE0_W14},
		'{`NODE1_W0, `NODE1_W1, `NODE1_W2, `NODE1_W3, `NODE1_W4, `NODE1_W5, `NODE1_W6,
			`NODE1_W7, `NODE1_W8, `NODE1_W9, `NODE1_W10, `NODE1_W11, `NODE1_W12,
			`NODE1_W13, `NODE1_W14},
		'{`NODE2_W0, `NODE2_W1, `NODE2_W2, `NODE2_W3, `NODE2_W4, `NODE2_W5, `NODE2_W6,
			`NODE2_W7, `NODE2_W8, `NODE2_W9, `NODE2_W10, `NODE2_W11, `NODE2_W12,
			`NODE2_W13, `NODE2_W14}
	};
	localparam logic [31:0] BIASES [`NN_NUM_NODES] = '{`NODE0_B, `NODE1_B, `NODE2_B};

	logic clk;
	logic rst;
	logic inValid;
	layerIn_t sampleIn;
	logic outValid;
	layerOut_t result;
	layerOut_t expQ [$];
	int cycleQ [$];
	int cycle = 0;
	layerOut_t lastResult;
	logic haveResult = 1'b0;

	neuron_layer i_neuron_layer
	(
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.sampleIn(sampleIn),
		.outValid(outValid),
		.result(result)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	// flush, multiply, truncate, then saturate the exponent.
	function automatic float32_t refMult(input float32_t x, input float32_t y);
		logic [47:0] p;
		int e;
		float32_t r;
		r = '0;
		r.sign = x.sign ^ y.sign;
		if (x.exponent == 0 || y.exponent == 0)
			return r;
		p = 48'({1'b1, x.mantissa}) * 48'({1'b1, y.mantissa});
		e = int'(x.exponent) + int'(y.exponent) - `NN_EXP_BIAS;
		if (p[47])
		begin
			p = p >> 1;
			e++;
		end
		if (e <= 0)
			return r;
		r.exponent = '1;
		if (e >= 255)
			return r;
		r.exponent = e[7:0];
		r.mantissa = p[45:23];
		return r;
	endfunction

	function automatic float32_t refAdd(input float32_t a, input float32_t b);
		float32_t hi;
		float32_t lo;
		float32_t r;
		logic [24:0] sigHi;
		logic [24:0] sigLo;
		int e;
		if (a.exponent == 0)
			a = '0;
		if (b.exponent == 0)
			b = '0;
		hi = (b[30:0] > a[30:0]) ? b : a;
		lo = (b[30:0] > a[30:0]) ? a : b;
		sigHi = (hi.exponent == 0) ? '0 : {2'b01, hi.mantissa};
		sigLo = (lo.exponent == 0) ? '0 : {2'b01, lo.mantissa};
		// alignment drops the low bits for good.
		sigLo = sigLo >> (hi.exponent - lo.exponent);
		sigHi = (hi.sign == lo.sign) ? sigHi + sigLo : sigHi - sigLo;
		r = '0;
		if (sigHi == 0)
			return r;
		r.sign = hi.sign;
		e = int'(hi.exponent);
		if (sigHi[24])
		begin
			sigHi = sigHi >> 1;
			e++;
		end
		while (!sigHi[23])
		begin
			sigHi = sigHi << 1;
			e--;
		end
		if (e <= 0)
			return r;
		r.exponent = '1;
		if (e >= 255)
			return r;
		r.exponent = e[7:0];
		r.mantissa = sigHi[22:0];
		return r;
	endfunction

	function automatic layerOut_t refLayer(input layerIn_t s);
		float32_t level [`NN_NUM_INPUTS+1];
		layerOut_t r;
		int width;
		for (int n = 0; n < `NN_NUM_NODES; n++)
		begin
			for (int k = 0; k < `NN_NUM_INPUTS; k++)
				level[k] = refMult(s.values[k], WEIGHTS[n][k]);
			level[`NN_NUM_INPUTS] = BIASES[n];
			// neighbours pair up level by level until one sum is left.
			for (width = `NN_NUM_INPUTS + 1; width > 1; width = width / 2)
				for (int k = 0; k < width / 2; k++)
					level[k] = refAdd(level[2 * k], level[2 * k + 1]);
			r.nodes[n] = (s.activation == ACT_RELU && level[0].sign) ? '0 : level[0];
		end
		return r;
	endfunction

	function automatic layerIn_t uniformSample(input logic [31:0] value, input activation_t act);
		layerIn_t s;
		s.activation = act;
		for (int k = 0; k < `NN_NUM_INPUTS; k++)
			s.values[k] = value;
		return s;
	endfunction

	function automatic layerIn_t randSample(input int expLo, input int expHi);
		layerIn_t s;
		s.activation = activation_t'($urandom_range(1, 0));
		for (int k = 0; k < `NN_NUM_INPUTS; k++)
			s.values[k] = {1'($urandom), 8'($urandom_range(expHi, expLo)), 23'($urandom)};
		return s;
	endfunction

	task automatic sendSample(input layerIn_t s);
		inValid = 1'b1;
		sampleIn = s;
		expQ.push_back(refLayer(s));
		cycleQ.push_back(cycle + 2);
		@(posedge clk);
		#1;
		inValid = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic waitDrain();
		int waited;
		waited = 0;
		while (expQ.size() > 0)
		begin
			if (waited == 20)
				reportFailure("timeout waiting for outValid");
			idle(1);
			waited++;
		end
	endtask

	always @(negedge clk)
	begin
		layerOut_t expected;
		int due;
		if (!rst && outValid === 1'b1)
		begin
			assert (expQ.size() > 0)
			else
				reportFailure("outValid went high with no sample in flight");
			expected = expQ.pop_front();
			due = cycleQ.pop_front();
			assert (cycle == due)
			else
				reportFailure($sformatf("FAILED outValid: expected cycle %h, got cycle %h",
					due, cycle));
			assert (result === expected)
			else
				reportFailure($sformatf("FAILED result: expected %h, got %h", expected, result));
			lastResult = result;
			haveResult = 1'b1;
		end
		else if (haveResult && outValid !== 1'b1)
		begin
			// without a strobe the last result stays in place.
			assert (result === lastResult)
			else
				reportFailure($sformatf("FAILED result: expected %h held, got %h",
					lastResult, result));
		end
	end

	initial
	begin
		layerIn_t s;
		activation_t act;
		void'($urandom(32'h66eb));
		rst = 1'b1;
		inValid = 1'b0;
		sampleIn = '0;
		idle(2);
		rst = 1'b0;

		// directed vectors in linear mode and then in relu mode.
		for (int m = 0; m < 2; m++)
		begin
			act = m ? ACT_RELU : ACT_LINEAR;
			sendSample(uniformSample(32'h3F800000, act));
			sendSample(uniformSample(32'hBF800000, act));
			s = uniformSample(32'h0, act);
			sendSample(s);
			s.values[7] = 32'h40000000;
			sendSample(s);
			waitDrain();
		end

		repeat (200)
			sendSample(randSample(100, 154));
		waitDrain();

		// every other input subnormal.
		repeat (10)
		begin
			s = randSample(100, 154);
			for (int k = 0; k < `NN_NUM_INPUTS; k += 2)
				s.values[k].exponent = '0;
			sendSample(s);
		end
		// products 2 and 3 of node 0 cancel exactly.
		s = uniformSample(32'h0, ACT_LINEAR);
		s.values[2] = 32'h3DF596DF;
		s.values[3] = 32'h3EDD70FD;
		sendSample(s);
		// product 14 of node 2 truncates to -0.125 and cancels its bias.
		s = uniformSample(32'h0, ACT_LINEAR);
		s.values[14] = 32'hBE241A43;
		sendSample(s);
		sendSample(uniformSample(32'h7F7FFFFF, ACT_LINEAR));
		repeat (10)
			sendSample(randSample(250, 254));
		waitDrain();

		repeat (20)
		begin
			sendSample(randSample(100, 154));
			idle($urandom_range(4, 1));
		end
		waitDrain();

		// the second sample enters with reset and both are lost.
		sendSample(randSample(100, 154));
		rst = 1'b1;
		inValid = 1'b1;
		sampleIn = randSample(100, 154);
		expQ.delete();
		cycleQ.delete();
		idle(1);
		inValid = 1'b0;
		idle(1);
		rst = 1'b0;
		idle(8);
		sendSample(randSample(100, 154));
		waitDrain();

		$display("PASS: all tests");
		$finish;
	end

endmodule
